//--- branch_resolve_top.f
+incdir+logic
logic/bru_isa_pkg.sv
logic/bru_pipe_pkg.sv
logic/branch_issue_queue.sv
logic/branch_resolve_unit.sv
logic/branch_history_table.sv
logic/branch_resolve_top.sv
tests/branch_resolve_chk.sv
tests/branch_resolve_tb.sv

//--- Bender.yml
package:
  name: branch_resolve

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/bru_isa_pkg.sv
      - logic/bru_pipe_pkg.sv
      - logic/branch_issue_queue.sv
      - logic/branch_resolve_unit.sv
      - logic/branch_history_table.sv
      - logic/branch_resolve_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/branch_resolve_chk.sv
      - tests/branch_resolve_tb.sv

//--- tests/branch_resolve_tb.sv
/*
 * Branch resolution subsystem testbench
 * Directed tests against a model of the resolution rules, the credit
 * protocol and the 2-bit history counters
 */
`default_nettype none
`include "bru_macros.svh"

module branch_resolve_tb;
  import bru_isa_pkg::*;
  import bru_pipe_pkg::*;

  localparam int DEPTH     = `BRU_BQ_DEPTH;
  localparam int BHT_IDX_W = $clog2(`BRU_BHT_ENTRIES);

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     op_valid;
  br_op_t                   op;
  logic [`BRU_CREDIT_W-1:0] credit_return;
  logic                     result_valid;
  br_result_t               result;
  logic                     flush;
  logic [`BRU_XLEN-1:0]     pred_pc;
  logic                     pred_taken;

  logic [31:0]          lfsr = 32'd6;             // Galois LFSR state
  int                   credits;                  // Upstream credit counter
  int                   errors = 0;
  int                   checks = 0;
  int                   n_results = 0;
  int                   n_flushes = 0;
  logic [1:0]           bht [`BRU_BHT_ENTRIES];   // Counter model
  br_result_t           exp_q [$];                // Results still owed in age order
  logic                 cond_q [$];               // Matching train flags
  logic [`BRU_XLEN-1:0] look_pc = '0;             // Fetch lookup address

  branch_resolve_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .op           (op),
    .credit_return(credit_return),
    .result_valid (result_valid),
    .result       (result),
    .flush        (flush),
    .pred_pc      (pred_pc),
    .pred_taken   (pred_taken)
  );

  always #5 clk = ~clk;

  // One shift per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_imm();
    logic [31:0] w;
    w = rand_bits(12);
    return {{19{w[11]}}, w[11:0], 1'b0};  // Branch offset range, even
  endfunction

  function automatic br_op_t make_op(input br_uop_t uop, input logic [31:0] rs1,
                                     input logic [31:0] rs2, input logic [31:0] imm,
                                     input logic [31:0] pc, input logic pred);
    return '{uop: uop, ops: '{rs1: rs1, rs2: rs2, imm: imm, pc: pc}, pred_taken: pred};
  endfunction

  // Resolution rules, written from the ISA definition
  function automatic br_result_t model_resolve(input br_op_t o);
    br_result_t  r;
    logic [31:0] a;
    logic [31:0] b;
    a = o.ops.rs1;
    b = o.ops.rs2;
    case (o.uop)
      BR_BEQ:  r.taken = (a == b);
      BR_BNE:  r.taken = (a != b);
      BR_BLT:  r.taken = ($signed(a) < $signed(b));
      BR_BGE:  r.taken = ($signed(a) >= $signed(b));
      BR_BLTU: r.taken = (a < b);
      BR_BGEU: r.taken = (a >= b);
      default: r.taken = 1'b1;                  // JAL and JALR
    endcase
    if (o.uop == BR_JALR) r.target = (a + o.ops.imm) & ~32'd1;
    else if (r.taken) r.target = o.ops.pc + o.ops.imm;
    else r.target = o.ops.pc + 32'd4;
    r.mispredict = (r.taken != o.pred_taken);
    r.pc         = o.ops.pc;
    return r;
  endfunction

  task automatic compare(input string test, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error [%s] %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $finish;
  endtask

  // Sampled 1 time unit after the falling edge once inputs have settled
  task automatic observe(input string test);
    br_result_t           e;
    logic                 cond;
    logic [BHT_IDX_W-1:0] idx;
    credits += credit_return;
    if (flush) n_flushes++;
    if (result_valid) n_results++;
    if (!result_valid) begin
      compare(test, "idle flush", 32'd0, 32'(flush));
    end else if (exp_q.size() == 0) begin
      errors++;
      $display("Test %s got a result for pc %h with no branch outstanding", test, result.pc);
    end else begin
      e    = exp_q.pop_front();
      cond = cond_q.pop_front();
      compare(test, "taken", 32'(e.taken), 32'(result.taken));
      compare(test, "target", e.target, result.target);
      compare(test, "pc", e.pc, result.pc);
      compare(test, "mispredict", 32'(e.mispredict), 32'(result.mispredict));
      compare(test, "flush", 32'(e.mispredict), 32'(flush));
      idx = e.pc[2 +: BHT_IDX_W];
      if (cond && e.taken && bht[idx] != 2'b11) bht[idx] = bht[idx] + 2'b01;
      else if (cond && !e.taken && bht[idx] != 2'b00) bht[idx] = bht[idx] - 2'b01;
      if (e.mispredict) begin
        exp_q.delete();                         // Younger ops are killed
        cond_q.delete();
      end
    end
  endtask

  task automatic step(input string test, input logic valid, input br_op_t o);
    @(negedge clk);
    op_valid = valid;
    op       = o;
    pred_pc  = look_pc;
    if (valid) begin
      credits--;                                // Spend a credit
      exp_q.push_back(model_resolve(o));
      cond_q.push_back(o.uop != BR_JAL && o.uop != BR_JALR);
    end
    #1;
    observe(test);
  endtask

  task automatic send(input string test, input br_op_t o);
    int waited;
    waited = 0;
    while (credits == 0 && waited < 50) begin
      step(test, 1'b0, '0);
      waited++;
    end
    if (credits == 0) abort_run($sformatf("No credit came back in time in test %s", test));
    else step(test, 1'b1, o);
  endtask

  // Wait until every expected result is in
  task automatic drain(input string test);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 100) begin
      step(test, 1'b0, '0);
      waited++;
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("Test %s timed out waiting for results", test));
    end
  endtask

  task automatic check_lookup(input string test, input logic [31:0] pc);
    look_pc = pc;
    step(test, 1'b0, '0);
    compare(test, "pred_taken", 32'(bht[pc[2 +: BHT_IDX_W]][1]), 32'(pred_taken));
  endtask

  task automatic do_reset();
    @(negedge clk);
    rst_n    = 1'b0;
    op_valid = 1'b0;
    repeat (3) @(negedge clk);
    rst_n   = 1'b1;
    credits = DEPTH;
    exp_q.delete();
    cond_q.delete();
    foreach (bht[i]) bht[i] = 2'b01;            // Weakly not taken
  endtask

  task automatic test_conditions();
    br_op_t      o;
    logic [31:0] a;
    logic [31:0] b;
    for (int k = 0; k < 6; k++) begin
      for (int n = 0; n < 5; n++) begin
        a = rand_bits(32);
        b = rand_bits(32);
        if (n == 0) b = a;                      // Equal operands
        if (n == 1) b = a ^ 32'h8000_0000;      // Only the sign bit differs
        if (n == 2) begin
          a = 32'h7fff_ffff;
          b = 32'h8000_0000;
        end
        o = make_op(br_uop_t'(4'(k)), a, b, rand_imm(), rand_bits(30) << 2, 1'b0);
        o.pred_taken = model_resolve(o).taken;  // Correct guess so no flush
        send("conditions", o);
      end
    end
    drain("conditions");
  endtask

  task automatic test_jumps();
    int f0;
    f0 = n_flushes;
    send("jumps", make_op(BR_JAL, rand_bits(32), 0, rand_imm(), rand_bits(30) << 2, 1'b1));
    send("jumps", make_op(BR_JALR, rand_bits(32) | 1, 0, rand_imm(), rand_bits(30) << 2, 1'b1));
    drain("jumps");
    send("jumps", make_op(BR_JAL, 0, 0, rand_imm(), rand_bits(30) << 2, 1'b0));
    drain("jumps");
    compare("jumps", "flush count", 32'(f0 + 1), 32'(n_flushes));
  endtask

  task automatic test_mispredict_kill();
    br_op_t burst [4];
    br_op_t o;
    int     r0;
    int     f0;
    burst[0] = make_op(BR_BEQ, 32'd5, 32'd5, rand_imm(), 32'h100, 1'b0);  // Taken but guessed not
    for (int i = 1; i < 4; i++) begin
      o = make_op(BR_BNE, rand_bits(32), rand_bits(32), rand_imm(), 32'h100 + 4 * i, 1'b0);
      o.pred_taken = model_resolve(o).taken;
      burst[i] = o;
    end
    r0 = n_results;
    f0 = n_flushes;
    for (int i = 0; i < 4; i++) begin
      if (n_flushes == f0) send("kill", burst[i]);  // Wrong path stops at the redirect
    end
    repeat (2) step("kill", 1'b0, '0);          // Killed ops would resolve in these cycles
    drain("kill");
    compare("kill", "result count", 32'(r0 + 1), 32'(n_results));
    compare("kill", "flush count", 32'(f0 + 1), 32'(n_flushes));
    compare("kill", "credits", 32'(DEPTH), 32'(credits));
    send("kill", make_op(BR_BLTU, 32'd1, 32'd2, 32'h20, 32'h200, 1'b1));
    drain("kill");
    compare("kill", "result after flush", 32'(r0 + 2), 32'(n_results));
  endtask

  task automatic test_credit_flow();
    br_op_t o;
    int     r0;
    r0 = n_results;
    for (int i = 0; i < 24; i++) begin
      o = make_op(br_uop_t'(4'(i % 6)), rand_bits(32), rand_bits(32), rand_imm(),
                  32'h1000 + 4 * i, 1'b0);
      o.pred_taken = model_resolve(o).taken;
      send("credits", o);                       // Results are matched in order by pc
    end
    drain("credits");
    compare("credits", "result count", 32'(r0 + 24), 32'(n_results));
    compare("credits", "final credits", 32'(DEPTH), 32'(credits));
  endtask

  task automatic test_training();
    logic [31:0] pc;
    pc = 32'h0000_0048;
    do_reset();                                 // Counters back to weakly not taken
    check_lookup("training", pc);
    for (int i = 0; i < 4; i++) begin
      send("training", make_op(i < 2 ? BR_BEQ : BR_BNE, 32'd7, 32'd7, 32'h40, pc, i < 2));
      drain("training");
      check_lookup("training", pc);
    end
    send("training", make_op(BR_JAL, 0, 0, 32'h40, pc, 1'b1));
    send("training", make_op(BR_JALR, 32'h800, 0, 32'h40, pc, 1'b1));
    drain("training");
    check_lookup("training", pc);               // Jumps leave the counter alone
  endtask

  initial begin
    int asrt_fails;
    rst_n    = 1'b0;
    op_valid = 1'b0;
    op       = '0;
    pred_pc  = '0;
    do_reset();
    test_conditions();
    test_jumps();
    test_mispredict_kill();
    test_credit_flow();
    test_training();
    repeat (3) step("idle", 1'b0, '0);          // Catch stray results
    asrt_fails = u_dut.u_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/branch_resolve_chk.sv
/*
 * Branch resolution protocol checker
 * Bound into the subsystem top. Watches credits held by the queue,
 * flush qualification and the dead cycles after a flush.
 */
`default_nettype none
`include "bru_macros.svh"

module branch_resolve_chk (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     op_valid,
  input logic [`BRU_CREDIT_W-1:0] credit_return,
  input logic                     result_valid,
  input bru_pipe_pkg::br_result_t result,
  input logic                     flush
);
  int unsigned fail_count = 0;  // Read by the testbench at the end
  int          held;            // Credits owned by the queue
  int          held_next;

  always_comb held_next = held + int'(op_valid) - int'(credit_return);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held <= 0;
    end else begin
      held <= held_next;
    end
  end

  credits_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    held >= 0 && held <= `BRU_BQ_DEPTH)
    else begin
      fail_count++;
      $error("credits in flight out of range: %0d", held);
    end

  // A flush hands back every credit still in flight
  flush_qualified: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> (result_valid && result.mispredict && held_next == 0))
    else begin
      fail_count++;
      $error("flush without a mispredicted result or with credits kept");
    end

  // The queue is empty after a flush so no result can appear for two cycles
  flush_dead_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !result_valid ##1 !result_valid)
    else begin
      fail_count++;
      $error("result shortly after a flush");
    end

endmodule

bind branch_resolve_top branch_resolve_chk u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .op_valid     (op_valid),
  .credit_return(credit_return),
  .result_valid (result_valid),
  .result       (result),
  .flush        (flush)
);

`default_nettype wire

//--- logic/branch_resolve_top.sv
/*
 * Branch resolution subsystem top
 * Issue queue feeding the resolver, whose training output updates
 * the history table read by fetch
 */
`default_nettype none
`include "bru_macros.svh"

module branch_resolve_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Dispatch side
  input  logic                     op_valid,
  input  bru_pipe_pkg::br_op_t     op,
  output logic [`BRU_CREDIT_W-1:0] credit_return,
  // Resolution outputs
  output logic                     result_valid,
  output bru_pipe_pkg::br_result_t result,
  output logic                     flush,
  // Fetch lookup
  input  logic [`BRU_XLEN-1:0]     pred_pc,
  output logic                     pred_taken
);
  import bru_pipe_pkg::*;

  logic       issue_valid;
  br_op_t     issue_op;
  bht_train_t train;

  branch_issue_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .op           (op),
    .flush        (flush),         // Resolver kills younger ops
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .credit_return(credit_return)
  );

  branch_resolve_unit u_resolve (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .result_valid(result_valid),
    .result      (result),
    .flush       (flush),
    .train       (train)
  );

  branch_history_table u_bht (
    .clk       (clk),
    .rst_n     (rst_n),
    .pred_pc   (pred_pc),
    .pred_taken(pred_taken),
    .train     (train)           // One update per conditional result
  );

endmodule

`default_nettype wire

//--- logic/branch_history_table.sv
/*
 * Branch history table
 * 2-bit saturating counters indexed by pc above bit 1.
 * Fetch reads combinationally and the resolver trains one counter
 * per resolved conditional branch.
 */
`default_nettype none
`include "bru_macros.svh"

module branch_history_table (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`BRU_XLEN-1:0]     pred_pc,     // Fetch address
  output logic                     pred_taken,
  input  bru_pipe_pkg::bht_train_t train
);
  localparam int         ENTRIES = `BRU_BHT_ENTRIES;
  localparam int         IDX_W   = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
  localparam logic [1:0] CNT_MAX = 2'b11;  // Strongly taken
  localparam logic [1:0] CNT_MIN = 2'b00;  // Strongly not taken
  localparam logic [1:0] WEAK_NT = 2'b01;  // Reset state

  logic [1:0]       cnt [ENTRIES];
  logic [IDX_W-1:0] pred_idx;
  logic [IDX_W-1:0] train_idx;
  logic [1:0]       train_cnt;   // Counter being trained

  // Bits [1:0] are always zero for 4-byte instructions
  assign pred_idx  = pred_pc[IDX_W+1:2];
  assign train_idx = train.pc[IDX_W+1:2];
  assign train_cnt = cnt[train_idx];

  assign pred_taken = cnt[pred_idx][1];  // Upper bit decides

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        cnt[i] <= WEAK_NT;
      end
    end else if (train.valid) begin
      if (train.taken) begin
        if (train_cnt != CNT_MAX) begin
          cnt[train_idx] <= train_cnt + 2'b01;  // Toward taken
        end
      end else begin
        if (train_cnt != CNT_MIN) begin
          cnt[train_idx] <= train_cnt - 2'b01;  // Toward not taken
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/branch_resolve_unit.sv
/*
 * Branch resolve unit
 * Evaluates the branch condition, computes the redirect target and
 * compares against the prediction. Outcome and training record are
 * registered. A mispredicted result raises flush in its own cycle.
 */
`default_nettype none
`include "bru_macros.svh"

module branch_resolve_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     issue_valid,
  input  bru_pipe_pkg::br_op_t     issue_op,
  output logic                     result_valid,
  output bru_pipe_pkg::br_result_t result,
  output logic                     flush,
  output bru_pipe_pkg::bht_train_t train
);
  import bru_isa_pkg::*;
  import bru_pipe_pkg::*;

  br_operands_t         ops;
  logic                 eq;           // rs1 == rs2
  logic                 lt_s;         // Signed rs1 < rs2
  logic                 lt_u;         // Unsigned rs1 < rs2
  logic                 taken;
  logic [`BRU_XLEN-1:0] jalr_sum;
  logic [`BRU_XLEN-1:0] target;
  logic                 capture;
  logic                 train_valid;  // Registered conditional flag

  assign ops  = issue_op.ops;
  assign eq   = (ops.rs1 == ops.rs2);
  assign lt_s = ($signed(ops.rs1) < $signed(ops.rs2));
  assign lt_u = (ops.rs1 < ops.rs2);

  // Condition decode
  always_comb begin
    case (issue_op.uop)
      BR_BEQ:          taken = eq;
      BR_BNE:          taken = ~eq;
      BR_BLT:          taken = lt_s;
      BR_BGE:          taken = ~lt_s;
      BR_BLTU:         taken = lt_u;
      BR_BGEU:         taken = ~lt_u;
      BR_JAL, BR_JALR: taken = 1'b1;  // Jumps always redirect
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_sum = ops.rs1 + ops.imm;

  // Redirect target
  always_comb begin
    if (issue_op.uop == BR_JALR) begin
      target = {jalr_sum[`BRU_XLEN-1:1], 1'b0};  // LSB forced low
    end else if (taken) begin
      target = ops.pc + ops.imm;
    end else begin
      target = ops.pc + `BRU_XLEN'(BR_INSN_BYTES);  // Fall through
    end
  end

  // An op issued while flushing is younger and dies here
  assign capture = issue_valid & ~flush;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      train_valid  <= 1'b0;
    end else begin
      result_valid <= capture;
      train_valid  <= capture & br_is_cond(issue_op.uop);
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      result.taken      <= taken;
      result.mispredict <= (taken != issue_op.pred_taken);
      result.target     <= target;
      result.pc         <= ops.pc;
    end
  end

  assign flush = result_valid & result.mispredict;  // Same cycle as result

  // Training shares the result register
  assign train = '{valid: train_valid, pc: result.pc, taken: result.taken};

endmodule

`default_nettype wire

//--- logic/branch_issue_queue.sv
/*
 * Branch issue queue
 * In-order circular FIFO fed by dispatch under credit flow control.
 * Head is offered every cycle the queue is non-empty. A flush empties
 * the queue, drops the incoming op and hands every freed credit back.
 */
`default_nettype none
`include "bru_macros.svh"

module branch_issue_queue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     op_valid,       // Dispatch holds a credit
  input  bru_pipe_pkg::br_op_t     op,
  input  logic                     flush,          // Kill everything younger
  output logic                     issue_valid,
  output bru_pipe_pkg::br_op_t     issue_op,
  output logic [`BRU_CREDIT_W-1:0] credit_return   // Entries freed this cycle
);
  import bru_pipe_pkg::*;

  localparam int DEPTH = `BRU_BQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  br_op_t                   mem [DEPTH];  // Entry storage
  logic [PTR_W-1:0]         rd_ptr;       // Head
  logic [PTR_W-1:0]         wr_ptr;       // Next free slot
  logic [`BRU_CREDIT_W-1:0] count;        // Occupied entries
  logic                     do_wr;
  logic                     do_rd;

  // Wrap explicitly so depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign issue_valid = (count != '0);   // Resolver never stalls
  assign issue_op    = mem[rd_ptr];

  // Flush cancels both the write and the issue of this cycle
  assign do_wr = op_valid & ~flush;
  assign do_rd = issue_valid & ~flush;

  always_comb begin
    if (flush) begin
      // Whole queue plus the op arriving right now
      credit_return = count + `BRU_CREDIT_W'(op_valid);
    end else begin
      credit_return = `BRU_CREDIT_W'(issue_valid);  // One per issue
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // Drop all entries
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + `BRU_CREDIT_W'(do_wr) - `BRU_CREDIT_W'(do_rd);
    end
  end

  // Credits keep the upstream from writing a full queue
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= op;
    end
  end

endmodule

`default_nettype wire

//--- logic/bru_pipe_pkg.sv
/*
 * Branch pipeline transport types
 * Payloads moving from dispatch into the queue, out of the
 * resolver and into the history table
 */
`default_nettype none
`include "bru_macros.svh"

package bru_pipe_pkg;
  import bru_isa_pkg::*;

  // One queue entry
  // Same layout as the dispatch payload
  typedef struct packed {
    br_uop_t      uop;         // Branch kind
    br_operands_t ops;         // Sources and pc
    logic         pred_taken;  // Front end guess
  } br_op_t;

  // Registered outcome of one branch
  typedef struct packed {
    logic                 taken;       // Condition held or jump
    logic                 mispredict;  // Outcome differs from guess
    logic [`BRU_XLEN-1:0] target;      // Next fetch address
    logic [`BRU_XLEN-1:0] pc;          // Branch address
  } br_result_t;

  // Counter update request
  typedef struct packed {
    logic                 valid;  // Conditional branch resolved
    logic [`BRU_XLEN-1:0] pc;     // Selects the counter
    logic                 taken;  // Count direction
  } bht_train_t;

endpackage

`default_nettype wire

//--- logic/bru_isa_pkg.sv
/*
 * Branch ISA definitions
 * Micro-op codes understood by the branch unit and the operand
 * bundle that travels with every issued branch
 */
`default_nettype none
`include "bru_macros.svh"

package bru_isa_pkg;

  // Conditional kinds first, jumps at the end
  typedef enum logic [3:0] {
    BR_BEQ  = 4'b0000,  // rs1 == rs2
    BR_BNE  = 4'b0001,  // rs1 != rs2
    BR_BLT  = 4'b0010,  // Signed less than
    BR_BGE  = 4'b0011,  // Signed greater or equal
    BR_BLTU = 4'b0100,  // Unsigned less than
    BR_BGEU = 4'b0101,  // Unsigned greater or equal
    BR_JAL  = 4'b0110,  // pc relative jump
    BR_JALR = 4'b0111   // Register indirect jump
  } br_uop_t;

  localparam int unsigned BR_INSN_BYTES = 4;  // Fall-through step

  // Source values read at issue
  typedef struct packed {
    logic [`BRU_XLEN-1:0] rs1;  // R[rs1]
    logic [`BRU_XLEN-1:0] rs2;  // R[rs2]
    logic [`BRU_XLEN-1:0] imm;  // Sign extended offset
    logic [`BRU_XLEN-1:0] pc;   // Address of the branch itself
  } br_operands_t;

  // Only conditional branches train the history table
  function automatic logic br_is_cond(br_uop_t uop);
    return !(uop inside {BR_JAL, BR_JALR});
  endfunction

endpackage

`default_nettype wire

//--- logic/bru_macros.svh
/*
 * Branch resolution subsystem sizing
 * Data width, issue queue depth, credit count width and
 * history table size shared by every block
 */
`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// Data and address width in bits
`define BRU_XLEN 32

// Issue queue entries
// Also the credits the dispatch side owns after reset
`define BRU_BQ_DEPTH 4

// 2-bit counters in the history table
// Indexed by pc bits above bit 1
`define BRU_BHT_ENTRIES 16

// Credit count width
// Must hold the value BRU_BQ_DEPTH itself
`define BRU_CREDIT_W 3

`endif
